//--- src/spi_cfg_pkg.sv
package spi_cfg_pkg;

    localparam int word_len = 8;                      // Bits per transfer
    localparam int presc_w = 3;                       // Prescale select width

    // Widest half-period count, 2**7 cycles at presc 7
    localparam int presc_cnt_w = 2**presc_w - 1;

    // Bit 1 is cpol, bit 0 is cpha
    typedef enum logic [1:0]
    {
        mode0 = 2'b00,
        mode1 = 2'b01,
        mode2 = 2'b10,
        mode3 = 2'b11
    } spi_mode_t;

    typedef struct packed
    {
        logic [presc_w-1:0] presc;                    // Half period is 2**presc cycles
        logic               lsb_first;
        spi_mode_t          mode;
    } spi_cfg_t;

endpackage

//--- src/spi_host_pkg.sv
package spi_host_pkg;

    localparam logic addr_data = 1'b0;                // Transmit buffer
    localparam logic addr_cfg = 1'b1;                 // Configuration word

    // One host write word, read as a byte or as config fields
    typedef union packed
    {
        logic [spi_cfg_pkg::word_len-1:0] tx_byte;
        struct packed
        {
            logic [1:0]            pad;
            spi_cfg_pkg::spi_cfg_t cfg;
        } cfg_view;
    } host_word_u;

endpackage

//--- src/spi_xfer_if.sv
`timescale 1ns/1ns

interface spi_xfer_if;
    import spi_cfg_pkg::*;

    logic                start;                       // Buffer holds a word
    logic [word_len-1:0] tx_data;
    spi_cfg_t            cfg;
    logic                taken;                       // Engine copied tx_data
    logic                done;                        // End of word, rx_data valid
    logic [word_len-1:0] rx_data;
    logic                busy;

    modport regs
    (
        output start, tx_data, cfg,
        input  taken, done, rx_data, busy
    );

    modport engine
    (
        input  start, tx_data, cfg,
        output taken, done, rx_data, busy
    );

endinterface

//--- src/spi_host_regs.sv
`timescale 1ns/1ns

module spi_host_regs
(
    input  logic                               wr,
    input  logic                               res_senderr,
    input  logic                               host_wr,
    input  logic                               host_addr,
    input  spi_host_pkg::host_word_u           host_wdata,
    input  logic                               host_rd,
    input  logic                               err_clr,
    output logic [spi_cfg_pkg::word_len-1:0]   host_rdata,
    output logic                               buff_empty,
    output logic                               send_err,
    output logic                               char_received,
    spi_xfer_if.regs                           xfer
);
    import spi_cfg_pkg::*;
    import spi_host_pkg::*;

    logic                buff_full;
    logic [word_len-1:0] tx_buf;
    spi_cfg_t            cfg_q;
    logic                wr_data;
    logic                wr_cfg;

    assign wr_data = host_wr && (host_addr == addr_data);
    assign wr_cfg = host_wr && (host_addr == addr_cfg);

    always_ff @(posedge wr or posedge res_senderr)
    begin
        if (res_senderr)
        begin
            buff_full <= 1'b0;
            send_err <= 1'b0;
            cfg_q <= '{presc: '0, lsb_first: 1'b0, mode: mode0};
        end
        else
        begin
            if (xfer.taken)
                buff_full <= 1'b0;
            else if (wr_data && !buff_full)
                buff_full <= 1'b1;

            if (wr_data && buff_full)
                send_err <= 1'b1;                     // Overrun, buffer left as is
            else if (err_clr)
                send_err <= 1'b0;

            if (wr_cfg)
                cfg_q <= host_wdata.cfg_view.cfg;
        end
    end

    always_ff @(posedge wr)
    begin
        if (wr_data && !buff_full)
            tx_buf <= host_wdata.tx_byte;
    end

    // A new word overwrites an unread one
    always_ff @(posedge wr or posedge res_senderr)
    begin
        if (res_senderr)
        begin
            host_rdata <= '0;
            char_received <= 1'b0;
        end
        else if (xfer.done)
        begin
            host_rdata <= xfer.rx_data;
            char_received <= 1'b1;
        end
        else if (host_rd)
            char_received <= 1'b0;
    end

    assign buff_empty = !buff_full;
    assign xfer.start = buff_full;
    assign xfer.tx_data = tx_buf;
    assign xfer.cfg = cfg_q;

    a_taken_full: assert property (@(posedge wr) disable iff (res_senderr)
        xfer.taken |-> !buff_empty)
        else $error("Engine took a word from an empty buffer");

    a_done_busy: assert property (@(posedge wr) disable iff (res_senderr)
        xfer.done |-> xfer.busy)
        else $error("End of word outside a transfer");

endmodule

//--- src/spi_clock_gen.sv
`timescale 1ns/1ns

module spi_clock_gen
(
    input  logic                              wr,
    input  logic                              res_senderr,
    input  logic                              enable,
    input  logic [spi_cfg_pkg::presc_w-1:0]   presc,
    output logic                              tick
);
    import spi_cfg_pkg::*;

    logic [presc_cnt_w-1:0] cnt;
    logic [presc_cnt_w-1:0] term_cnt;

    // 2**presc - 1, wraps to all ones at presc 7
    assign term_cnt = (presc_cnt_w'(1) << presc) - presc_cnt_w'(1);

    always_ff @(posedge wr or posedge res_senderr)
    begin
        if (res_senderr)
            cnt <= '0;
        else if (!enable || cnt == term_cnt)
            cnt <= '0;                                // Restart each period
        else
            cnt <= cnt + 1'b1;
    end

    assign tick = enable && (cnt == term_cnt);

    // presc must hold still while the divider runs
    a_cnt_range: assert property (@(posedge wr) disable iff (res_senderr)
        enable |-> cnt <= term_cnt)
        else $error("Divider count past the end of its half period");

endmodule

//--- src/spi_shift_engine.sv
`timescale 1ns/1ns

module spi_shift_engine
(
    input  logic                              wr,
    input  logic                              res_senderr,
    spi_xfer_if.engine                        xfer,
    input  logic                              tick,
    output logic                              clk_en,
    output logic [spi_cfg_pkg::presc_w-1:0]   presc,
    output logic                              sck,
    output logic                              mosi,
    input  logic                              miso,
    output logic                              ss
);
    import spi_cfg_pkg::*;

    spi_cfg_t                          cfg_q;
    logic                              busy_q;
    logic                              done_q;
    logic                              sck_q;         // Phase, 0 at idle level
    logic                              ss_q;
    logic                              mosi_q;
    logic [$clog2(2*word_len)-1:0]     half_cnt;
    logic [word_len-1:0]               tx_sr;
    logic [word_len-1:0]               rx_sr;
    logic                              accept;
    logic                              sample_edge;
    logic                              last_half;

    function automatic logic head_bit(input logic [word_len-1:0] w, input logic lsb);
        return lsb ? w[0] : w[word_len-1];
    endfunction

    function automatic logic [word_len-1:0] shift_out(input logic [word_len-1:0] w,
                                                      input logic lsb);
        return lsb ? {1'b1, w[word_len-1:1]} : {w[word_len-2:0], 1'b1};
    endfunction

    // Take a word when idle or in the done cycle
    assign accept = xfer.start && (!busy_q || done_q);
    assign sample_edge = (half_cnt[0] == cfg_q.mode[0]);  // Leading edge for cpha 0
    assign last_half = (half_cnt == '1);

    always_ff @(posedge wr or posedge res_senderr)
    begin
        if (res_senderr)
        begin
            cfg_q <= '{presc: '0, lsb_first: 1'b0, mode: mode0};
            busy_q <= 1'b0;
            done_q <= 1'b0;
            sck_q <= 1'b0;
            ss_q <= 1'b1;
            half_cnt <= '0;
        end
        else
        begin
            done_q <= busy_q && tick && last_half;
            if (accept || !busy_q)
                cfg_q <= xfer.cfg;                    // Frozen while a word runs
            if (accept)
            begin
                busy_q <= 1'b1;
                ss_q <= 1'b0;
                half_cnt <= '0;
            end
            else if (done_q)
            begin
                busy_q <= 1'b0;
                ss_q <= 1'b1;
            end
            else if (busy_q && tick)
            begin
                half_cnt <= half_cnt + 1'b1;
                sck_q <= !sck_q;
            end
        end
    end

    always_ff @(posedge wr)
    begin
        if (accept)
        begin
            mosi_q <= head_bit(xfer.tx_data, xfer.cfg.lsb_first);
            // With cpha 0 the first bit is already out
            tx_sr <= xfer.cfg.mode[0] ? xfer.tx_data
                                      : shift_out(xfer.tx_data, xfer.cfg.lsb_first);
        end
        else if (busy_q && tick)
        begin
            if (sample_edge)
                rx_sr <= cfg_q.lsb_first ? {miso, rx_sr[word_len-1:1]}
                                         : {rx_sr[word_len-2:0], miso};
            else
            begin
                mosi_q <= head_bit(tx_sr, cfg_q.lsb_first);
                tx_sr <= shift_out(tx_sr, cfg_q.lsb_first);
            end
        end
    end

    assign clk_en = busy_q && !done_q;                // Divider restarts between words
    assign presc = cfg_q.presc;
    assign sck = sck_q ^ cfg_q.mode[1];
    assign ss = ss_q;
    assign mosi = ss_q ? 1'b1 : mosi_q;

    assign xfer.taken = accept;
    assign xfer.done = done_q;
    assign xfer.rx_data = rx_sr;
    assign xfer.busy = busy_q;

    // 16 half periods bring sck back to cpol
    a_sck_idle: assert property (@(posedge wr) disable iff (res_senderr)
        ss |-> sck == cfg_q.mode[1])
        else $error("sck off its idle level while ss is high");

endmodule

//--- src/spi_master_top.sv
`timescale 1ns/1ns

module spi_master_top
(
    input  logic       wr,
    input  logic       res_senderr,
    input  logic       host_wr,
    input  logic       host_addr,
    input  logic [7:0] host_wdata,
    input  logic       host_rd,
    input  logic       err_clr,
    output logic [7:0] host_rdata,
    output logic       buff_empty,
    output logic       send_err,
    output logic       char_received,
    output logic       sck,
    output logic       mosi,
    input  logic       miso,
    output logic       ss
);
    import spi_cfg_pkg::*;

    logic               clk_en;
    logic               tick;
    logic [presc_w-1:0] presc;

    spi_xfer_if xfer_i ();

    spi_host_regs spi_host_regs_i
    (
        .wr            (wr),
        .res_senderr   (res_senderr),
        .host_wr       (host_wr),
        .host_addr     (host_addr),
        .host_wdata    (host_wdata),
        .host_rd       (host_rd),
        .err_clr       (err_clr),
        .host_rdata    (host_rdata),
        .buff_empty    (buff_empty),
        .send_err      (send_err),
        .char_received (char_received),
        .xfer          (xfer_i.regs)
    );

    spi_clock_gen spi_clock_gen_i
    (
        .wr          (wr),
        .res_senderr (res_senderr),
        .enable      (clk_en),
        .presc       (presc),
        .tick        (tick)
    );

    spi_shift_engine spi_shift_engine_i
    (
        .wr          (wr),
        .res_senderr (res_senderr),
        .xfer        (xfer_i.engine),
        .tick        (tick),
        .clk_en      (clk_en),
        .presc       (presc),
        .sck         (sck),
        .mosi        (mosi),
        .miso        (miso),
        .ss          (ss)
    );

endmodule

//--- tb/spi_slave_model.sv
`timescale 1ns/1ns

module spi_slave_model
(
    input  logic       sck,
    input  logic       ss,
    input  logic       mosi,
    output logic       miso,
    input  logic [1:0] mode,
    input  logic       lsb_first,
    input  logic [7:0] answer,
    output logic [7:0] rx_byte,
    output logic [7:0] rx_seq,                        // Arrival order, first bit at [7]
    output int         rx_words
);
    logic [7:0] tx_word;
    logic [7:0] rx_sr;
    int         tx_idx;
    int         rx_bits;

    task automatic drive_bit();
        if (tx_idx < 8)
            miso = lsb_first ? tx_word[tx_idx] : tx_word[7 - tx_idx];
        tx_idx++;
    endtask

    initial
    begin
        miso = 1'b1;
        rx_byte = '0;
        rx_seq = '0;
        rx_words = 0;
        tx_idx = 0;
        rx_bits = 0;
    end

    always @(negedge ss)
    begin
        tx_word = answer;
        tx_idx = 0;
        rx_bits = 0;
        if (!mode[0])
            drive_bit();                              // First bit out before any edge
    end

    always @(posedge ss)
        miso = 1'b1;

    always @(sck)
    begin
        if (ss === 1'b0)
        begin
            if ((sck !== mode[1]) ^ mode[0])          // Sample edge
            begin
                rx_sr = {rx_sr[6:0], mosi};
                rx_bits++;
                if (rx_bits == 8)
                begin
                    rx_seq = rx_sr;
                    for (int i = 0; i < 8; i++)
                        rx_byte[i] = lsb_first ? rx_sr[7 - i] : rx_sr[i];
                    rx_words++;
                    rx_bits = 0;
                    tx_word = answer;                 // Next word when ss stays low
                    tx_idx = 0;
                end
            end
            else
                drive_bit();
        end
    end

endmodule

//--- tb/spi_master_tb.sv
`timescale 1ns/1ns

module spi_master_tb;
    import spi_host_pkg::*;

    localparam int timeout_cycles = 2000;

    logic       wr;
    logic       res_senderr;
    logic       host_wr;
    logic       host_addr;
    logic [7:0] host_wdata;
    logic       host_rd;
    logic       err_clr;
    logic [7:0] host_rdata;
    logic       buff_empty;
    logic       send_err;
    logic       char_received;
    logic       sck;
    logic       mosi;
    logic       miso;
    logic       ss;

    logic [1:0] slave_mode;
    logic       slave_lsb;
    logic [7:0] slave_answer;
    logic [7:0] slave_byte;
    logic [7:0] slave_seq;
    int         slave_words;

    logic [15:0] lfsr;
    int          err_cnt = 0;
    int          words_seen = 0;
    logic        flag_prev = 1'b0;
    logic [7:0]  exp_val;
    logic [7:0]  exp_tx[$];                           // Bytes the slave must see
    logic [7:0]  exp_rx[$];                           // Bytes host_rdata must show

    spi_master_top spi_master_top_i
    (
        .wr            (wr),
        .res_senderr   (res_senderr),
        .host_wr       (host_wr),
        .host_addr     (host_addr),
        .host_wdata    (host_wdata),
        .host_rd       (host_rd),
        .err_clr       (err_clr),
        .host_rdata    (host_rdata),
        .buff_empty    (buff_empty),
        .send_err      (send_err),
        .char_received (char_received),
        .sck           (sck),
        .mosi          (mosi),
        .miso          (miso),
        .ss            (ss)
    );

    spi_slave_model slave_i
    (
        .sck       (sck),
        .ss        (ss),
        .mosi      (mosi),
        .miso      (miso),
        .mode      (slave_mode),
        .lsb_first (slave_lsb),
        .answer    (slave_answer),
        .rx_byte   (slave_byte),
        .rx_seq    (slave_seq),
        .rx_words  (slave_words)
    );

    initial
    begin
        wr = 1'b0;
        forever #2 wr = ~wr;
    end

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic report_value(input string name, input logic [7:0] got,
                                input logic [7:0] exp);
        err_cnt++;
        $display("[FAIL] %0t ns %s: got 0x%h, expected 0x%h", $time, name, got, exp);
        abort_run();
    endtask

    task automatic report_problem(input string what);
        err_cnt++;
        $display("[ERROR] %0t ns: %s", $time, what);
        abort_run();
    endtask

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [7:0] val);
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            val = {val[6:0], lfsr[0]};
        end
    endtask

    // Order of bits on the line, first bit at [7]
    function automatic logic [7:0] expected_seq(input logic [7:0] b, input logic lsb);
        logic [7:0] seq;
        for (int i = 0; i < 8; i++)
            seq[7 - i] = lsb ? b[i] : b[7 - i];
        return seq;
    endfunction

    task automatic host_write(input logic addr, input logic [7:0] data);
        host_wr = 1'b1;
        host_addr = addr;
        host_wdata = data;
        @(posedge wr);
        #1;
        host_wr = 1'b0;
    endtask

    task automatic read_rx();
        host_rd = 1'b1;
        @(posedge wr);
        #1;
        host_rd = 1'b0;
        assert (char_received === 1'b0)
            else report_value("char_received", char_received, 1'b0);
    endtask

    task automatic wait_ss(input logic level);
        int n;
        n = 0;
        do
        begin
            @(posedge wr);
            n++;
        end
        while (ss !== level && n < timeout_cycles);
        #1;
        if (ss !== level)
            report_problem("ss did not reach the expected level in time");
    endtask

    task automatic await_char();
        int n;
        n = 0;
        do
        begin
            @(posedge wr);
            n++;
        end
        while (char_received !== 1'b1 && n < timeout_cycles);
        #1;
        if (char_received !== 1'b1)
            report_problem("char_received did not rise in time");
    endtask

    task automatic check_idle();
        assert (ss === 1'b1) else report_value("ss", ss, 1'b1);
        assert (sck === slave_mode[1]) else report_value("sck", sck, slave_mode[1]);
        assert (mosi === 1'b1) else report_value("mosi", mosi, 1'b1);
    endtask

    task automatic configure(input logic [1:0] mode, input logic lsb);
        logic [7:0] r;
        logic [2:0] presc;
        take_bits(2, r);
        presc = 3'(r % 8'd3);
        slave_mode = mode;
        slave_lsb = lsb;
        host_write(addr_cfg, {2'b00, presc, lsb, mode});
        repeat (2) @(posedge wr);
        #1;
        check_idle();
    endtask

    task automatic run_exchange(input logic [1:0] mode, input logic lsb);
        logic [7:0] tx;
        logic [7:0] ans;
        configure(mode, lsb);
        take_bits(8, tx);
        take_bits(8, ans);
        slave_answer = ans;
        exp_tx.push_back(tx);
        exp_rx.push_back(ans);
        host_write(addr_data, tx);
        assert (buff_empty === 1'b0) else report_value("buff_empty", buff_empty, 1'b0);
        await_char();
        check_idle();
        repeat (5)                                    // Flag holds until the host reads
        begin
            @(posedge wr);
            assert (char_received === 1'b1)
                else report_value("char_received", char_received, 1'b1);
        end
        #1;
        read_rx();
    endtask

    task automatic run_overrun();
        logic [7:0] r;
        logic [7:0] first;
        logic [7:0] second;
        logic [7:0] ans;
        take_bits(3, r);
        configure(r[1:0], r[2]);
        take_bits(8, first);
        take_bits(8, second);
        take_bits(8, ans);
        if (second == first)
            second = ~first;
        slave_answer = ans;
        exp_tx.push_back(first);
        exp_rx.push_back(ans);
        host_write(addr_data, first);
        assert (buff_empty === 1'b0) else report_value("buff_empty", buff_empty, 1'b0);
        host_write(addr_data, second);               // Lands on a full buffer
        assert (send_err === 1'b1) else report_value("send_err", send_err, 1'b1);
        await_char();
        read_rx();
        assert (send_err === 1'b1) else report_value("send_err", send_err, 1'b1);
        err_clr = 1'b1;
        @(posedge wr);
        #1;
        err_clr = 1'b0;
        assert (send_err === 1'b0) else report_value("send_err", send_err, 1'b0);
    endtask

    task automatic run_back_to_back();
        logic [7:0] r;
        logic [7:0] w1;
        logic [7:0] w2;
        logic [7:0] a1;
        logic [7:0] a2;
        int base;
        int n;
        take_bits(3, r);
        configure(r[1:0], r[2]);
        take_bits(8, w1);
        take_bits(8, w2);
        take_bits(8, a1);
        take_bits(8, a2);
        exp_tx.push_back(w1);
        exp_tx.push_back(w2);
        exp_rx.push_back(a1);
        exp_rx.push_back(a2);
        base = slave_words;
        slave_answer = a1;
        host_write(addr_data, w1);
        wait_ss(1'b0);
        slave_answer = a2;                            // Slave loads it after the first word
        host_write(addr_data, w2);
        n = 0;
        while (slave_words < base + 2 && n < timeout_cycles)
        begin
            @(posedge wr);
            assert (ss === 1'b0) else report_value("ss", ss, 1'b0);
            #1;
            host_rd = char_received;                  // Read word one before word two ends
            n++;
        end
        host_rd = 1'b0;
        if (slave_words < base + 2)
            report_problem("The second back-to-back word did not arrive in time");
        await_char();
        read_rx();
    endtask

    // Compare each finished word against the queued expectations
    always @(posedge wr)
    begin
        if (slave_words != words_seen)
        begin
            words_seen = slave_words;
            if (exp_tx.size() == 0)
                report_problem("The slave received a word that was never written");
            else
            begin
                exp_val = exp_tx.pop_front();
                assert (slave_byte === exp_val)
                    else report_value("slave rx_byte", slave_byte, exp_val);
                assert (slave_seq === expected_seq(exp_val, slave_lsb))
                    else report_value("mosi bit order", slave_seq,
                                      expected_seq(exp_val, slave_lsb));
            end
        end
        if (char_received === 1'b1 && flag_prev !== 1'b1)
        begin
            if (exp_rx.size() == 0)
                report_problem("char_received rose with no word outstanding");
            else
            begin
                exp_val = exp_rx.pop_front();
                assert (host_rdata === exp_val)
                    else report_value("host_rdata", host_rdata, exp_val);
            end
        end
        flag_prev = char_received;
    end

    initial
    begin
        logic [7:0] r;
        lfsr = 16'd56;
        host_wr = 1'b0;
        host_addr = 1'b0;
        host_wdata = '0;
        host_rd = 1'b0;
        err_clr = 1'b0;
        slave_mode = 2'd0;
        slave_lsb = 1'b0;
        slave_answer = '0;
        res_senderr = 1'b1;
        repeat (4) @(posedge wr);
        #1;
        res_senderr = 1'b0;
        check_idle();
        assert (buff_empty === 1'b1) else report_value("buff_empty", buff_empty, 1'b1);
        assert (send_err === 1'b0) else report_value("send_err", send_err, 1'b0);
        assert (char_received === 1'b0)
            else report_value("char_received", char_received, 1'b0);
        assert (host_rdata === 8'h00) else report_value("host_rdata", host_rdata, 8'h00);

        for (int m = 0; m < 4; m++)                   // All four modes
        begin
            take_bits(1, r);
            run_exchange(2'(m), r[0]);
        end
        repeat (3)
        begin
            take_bits(2, r);
            run_exchange(r[1:0], 1'b1);
        end
        run_overrun();
        repeat (2) run_back_to_back();

        repeat (4) @(posedge wr);
        #1;
        if (exp_tx.size() != 0 || exp_rx.size() != 0)
            report_problem("Some written words never arrived");
        if (err_cnt == 0)
        begin
            $display("Finished with no errors");
            $finish;
        end
        else
            abort_run();
    end

endmodule

//--- spi_master_sys.f
src/spi_cfg_pkg.sv
src/spi_host_pkg.sv
src/spi_xfer_if.sv
src/spi_host_regs.sv
src/spi_clock_gen.sv
src/spi_shift_engine.sv
src/spi_master_top.sv
tb/spi_slave_model.sv
tb/spi_master_tb.sv

//--- Bender.yml
package:
  name: spi_master_sys

sources:
  - src/spi_cfg_pkg.sv
  - src/spi_host_pkg.sv
  - src/spi_xfer_if.sv
  - src/spi_host_regs.sv
  - src/spi_clock_gen.sv
  - src/spi_shift_engine.sv
  - src/spi_master_top.sv
  - target: test
    files:
      - tb/spi_slave_model.sv
      - tb/spi_master_tb.sv
